// ==== gfx_vga_stripe.f ====
+incdir+include
hw/gfx_pkg.sv
hw/fb_bank.sv
hw/stripe_writer.sv
hw/vga_timing.sv
hw/stripe_merge.sv
hw/gfx_vga_stripe.sv
testbench/tb_gfx_vga_stripe.sv

// ==== hw/fb_bank.sv ====
`default_nettype none

`include "gfx_defs.svh"

module fb_bank
  import gfx_pkg::*;
(
  input  logic       clk,

  input  logic       wr_en,
  input  bank_addr_t wr_addr,
  input  pixel_t     wr_data,

  input  logic       rd_en,
  input  bank_addr_t rd_addr,
  output pixel_t     rd_data
);

  pixel_t mem [`GFX_BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read returns old data on a same-edge write
  // output holds between fetches
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // a write to an unknown index would smear over the whole stripe
  wr_addr_known_a : assert property (
    @(posedge clk) wr_en |-> !$isunknown(wr_addr)
  );

endmodule

`default_nettype wire

// ==== hw/gfx_pkg.sv ====
`default_nettype none

`include "gfx_defs.svh"

package gfx_pkg;

  // red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [`GFX_PIXEL_BITS-1:0] pixel_t;

  // (y*16 + x) / 2, word index inside one stripe
  typedef logic [`GFX_BANK_ADDR_BITS-1:0] bank_addr_t;

  typedef enum logic {
    WR_IDLE,
    WR_CLEAR
  } wr_state_e;

  typedef enum logic [1:0] {
    PH_VISIBLE,
    PH_FRONT,
    PH_SYNC,
    PH_BACK
  } scan_phase_e;

endpackage

`default_nettype wire

// ==== hw/gfx_vga_stripe.sv ====
`default_nettype none

`include "gfx_defs.svh"

module gfx_vga_stripe
  import gfx_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // drawing client
  input  logic [`GFX_X_BITS-1:0] gfx_x,
  input  logic [`GFX_Y_BITS-1:0] gfx_y,
  input  pixel_t                 gfx_color,
  input  logic                   gfx_valid,
  input  logic                   gfx_clear,
  output logic                   gfx_ready,
  output logic                   gfx_vsync,

  // display side
  input  logic                   vga_enable,
  output pixel_t                 vga_color,
  output logic                   vga_hsync,
  output logic                   vga_vsync,
  output logic                   vga_visible
);

  // writer to stripes
  logic       wr0_en;
  bank_addr_t wr0_addr;
  pixel_t     wr0_data;
  logic       wr1_en;
  bank_addr_t wr1_addr;
  pixel_t     wr1_data;

  // scan and fetch
  logic       scan_hsync;
  logic       scan_vsync;
  logic       scan_visible;
  logic       fetch;
  bank_addr_t fetch_addr;

  // stripe read data
  pixel_t     even_data;
  pixel_t     odd_data;

  stripe_writer stripe_writer_i (
    .clk      (clk),
    .rst      (rst),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_clear(gfx_clear),
    .gfx_ready(gfx_ready),
    .wr0_en   (wr0_en),
    .wr0_addr (wr0_addr),
    .wr0_data (wr0_data),
    .wr1_en   (wr1_en),
    .wr1_addr (wr1_addr),
    .wr1_data (wr1_data)
  );

  // even columns
  fb_bank bank0_i (
    .clk    (clk),
    .wr_en  (wr0_en),
    .wr_addr(wr0_addr),
    .wr_data(wr0_data),
    .rd_en  (fetch),
    .rd_addr(fetch_addr),
    .rd_data(even_data)
  );

  // odd columns
  fb_bank bank1_i (
    .clk    (clk),
    .wr_en  (wr1_en),
    .wr_addr(wr1_addr),
    .wr_data(wr1_data),
    .rd_en  (fetch),
    .rd_addr(fetch_addr),
    .rd_data(odd_data)
  );

  vga_timing vga_timing_i (
    .clk       (clk),
    .rst       (rst),
    .enable    (vga_enable),
    .hsync     (scan_hsync),
    .vsync     (scan_vsync),
    .visible   (scan_visible),
    .fetch     (fetch),
    .fetch_addr(fetch_addr)
  );

  stripe_merge stripe_merge_i (
    .clk       (clk),
    .rst       (rst),
    .enable    (vga_enable),
    .hsync_in  (scan_hsync),
    .vsync_in  (scan_vsync),
    .visible_in(scan_visible),
    .fetch     (fetch),
    .even_data (even_data),
    .odd_data  (odd_data),
    .color     (vga_color),
    .hsync     (vga_hsync),
    .vsync     (vga_vsync),
    .visible   (vga_visible)
  );

  // early vsync for the client, two cycles ahead of vga_vsync
  assign gfx_vsync = scan_vsync;

endmodule

`default_nettype wire

// ==== hw/stripe_merge.sv ====
`default_nettype none

module stripe_merge
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   enable,

  // scan signals at counter time
  input  logic   hsync_in,
  input  logic   vsync_in,
  input  logic   visible_in,
  input  logic   fetch,

  // bank words, valid one cycle after fetch
  input  pixel_t even_data,
  input  pixel_t odd_data,

  output pixel_t color,
  output logic   hsync,
  output logic   vsync,
  output logic   visible
);

  logic   hsync_d;
  logic   vsync_d;
  logic   visible_d;
  logic   sel;
  pixel_t odd_hold;

  // stage one, lines up with rd_data
  // sel is 0 in the cycle after a fetch, 1 otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      visible_d <= 1'b0;
      sel       <= 1'b1;
    end else if (enable) begin
      hsync_d   <= hsync_in;
      vsync_d   <= vsync_in;
      visible_d <= visible_in;
      sel       <= !fetch;
    end
  end

  // keep the odd word for the cycle after the even one
  always_ff @(posedge clk) begin
    if (enable && !sel) begin
      odd_hold <= odd_data;
    end
  end

  // stage two, the output registers
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      visible <= 1'b0;
      color   <= '0;
    end else if (enable) begin
      hsync   <= hsync_d;
      vsync   <= vsync_d;
      visible <= visible_d;
      if (!visible_d) begin
        color <= '0;
      end else if (sel) begin
        color <= odd_hold;
      end else begin
        color <= even_data;
      end
    end
  end

  // a new pair may only start once the previous odd pixel is out
  sel_odd_on_fetch_a : assert property (
    @(posedge clk) disable iff (rst) fetch |-> sel
  );

endmodule

`default_nettype wire

// ==== hw/stripe_writer.sv ====
`default_nettype none

`include "gfx_defs.svh"

module stripe_writer
  import gfx_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // pixel write port from the drawing client
  input  logic [`GFX_X_BITS-1:0] gfx_x,
  input  logic [`GFX_Y_BITS-1:0] gfx_y,
  input  pixel_t                 gfx_color,
  input  logic                   gfx_valid,
  input  logic                   gfx_clear,
  output logic                   gfx_ready,

  // even column stripe
  output logic                   wr0_en,
  output bank_addr_t             wr0_addr,
  output pixel_t                 wr0_data,

  // odd column stripe
  output logic                   wr1_en,
  output bank_addr_t             wr1_addr,
  output pixel_t                 wr1_data
);

  wr_state_e  state;
  bank_addr_t clr_idx;
  pixel_t     fill_color;
  bank_addr_t pix_idx;
  logic       accept;

  // drop x bit 0, it only picks the stripe
  assign pix_idx = {gfx_y, gfx_x[`GFX_X_BITS-1:1]};

  assign gfx_ready = (state == WR_IDLE) && !gfx_clear;
  assign accept    = gfx_valid && gfx_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= WR_IDLE;
      clr_idx <= '0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (gfx_clear) begin
            state   <= WR_CLEAR;
            clr_idx <= '0;
          end
        end
        WR_CLEAR: begin
          // last index written, back to pixel writes
          if (clr_idx == '1) begin
            state <= WR_IDLE;
          end
          clr_idx <= clr_idx + 1'b1;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // fill color is payload, captured with the strobe
  always_ff @(posedge clk) begin
    if (state == WR_IDLE && gfx_clear) begin
      fill_color <= gfx_color;
    end
  end

  always_comb begin
    if (state == WR_CLEAR) begin
      // both stripes swept in lock step
      wr0_en   = 1'b1;
      wr1_en   = 1'b1;
      wr0_addr = clr_idx;
      wr1_addr = clr_idx;
      wr0_data = fill_color;
      wr1_data = fill_color;
    end else begin
      wr0_en   = accept && !gfx_x[0];
      wr1_en   = accept && gfx_x[0];
      wr0_addr = pix_idx;
      wr1_addr = pix_idx;
      wr0_data = gfx_color;
      wr1_data = gfx_color;
    end
  end

  no_ready_in_clear_a : assert property (
    @(posedge clk) disable iff (rst) (state == WR_CLEAR) |-> !gfx_ready
  );

  one_stripe_in_idle_a : assert property (
    @(posedge clk) disable iff (rst) (state == WR_IDLE) |-> !(wr0_en && wr1_en)
  );

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`default_nettype none

`include "gfx_defs.svh"

module vga_timing
  import gfx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,

  output logic       hsync,
  output logic       vsync,
  output logic       visible,

  // paired read strobe to both stripes
  output logic       fetch,
  output bank_addr_t fetch_addr
);

  localparam int H_BITS = $clog2(`GFX_H_WHOLE);
  localparam int V_BITS = $clog2(`GFX_V_WHOLE);

  logic [H_BITS-1:0] h_count;
  logic [V_BITS-1:0] v_count;
  scan_phase_e       h_phase;
  scan_phase_e       v_phase;

  function automatic scan_phase_e phase_of(
    input int pos,
    input int vis,
    input int front,
    input int sync
  );
    scan_phase_e ph;
    if (pos < vis) begin
      ph = PH_VISIBLE;
    end else if (pos < vis + front) begin
      ph = PH_FRONT;
    end else if (pos < vis + front + sync) begin
      ph = PH_SYNC;
    end else begin
      ph = PH_BACK;
    end
    return ph;
  endfunction

  // scan position, frozen while enable is low
  always_ff @(posedge clk) begin
    if (rst) begin
      h_count <= '0;
      v_count <= '0;
    end else if (enable) begin
      if (h_count == H_BITS'(`GFX_H_WHOLE - 1)) begin
        h_count <= '0;
        if (v_count == V_BITS'(`GFX_V_WHOLE - 1)) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + 1'b1;
        end
      end else begin
        h_count <= h_count + 1'b1;
      end
    end
  end

  assign h_phase = phase_of(int'(h_count), `GFX_H_VISIBLE, `GFX_H_FRONT, `GFX_H_SYNC);
  assign v_phase = phase_of(int'(v_count), `GFX_V_VISIBLE, `GFX_V_FRONT, `GFX_V_SYNC);

  // syncs are active low
  assign hsync   = (h_phase != PH_SYNC);
  assign vsync   = (v_phase != PH_SYNC);
  assign visible = (h_phase == PH_VISIBLE) && (v_phase == PH_VISIBLE);

  // one read per even column covers the odd neighbour too
  assign fetch      = enable && visible && !h_count[0];
  assign fetch_addr = {v_count[`GFX_Y_BITS-1:0], h_count[`GFX_X_BITS-1:1]};

  // fetch stays inside the visible window of the raw counters
  fetch_in_visible_a : assert property (
    @(posedge clk) disable iff (rst)
      fetch |-> (h_count < H_BITS'(`GFX_H_VISIBLE))
                && (v_count < V_BITS'(`GFX_V_VISIBLE))
  );

  // the odd column between two fetches never reads
  fetch_isolated_a : assert property (
    @(posedge clk) disable iff (rst) fetch |=> !fetch
  );

endmodule

`default_nettype wire

// ==== include/gfx_defs.svh ====
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// horizontal timing, in clk cycles
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT   2
`define GFX_H_SYNC    3
`define GFX_H_BACK    3
`define GFX_H_WHOLE   (`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

// vertical timing, in lines
`define GFX_V_VISIBLE 8
`define GFX_V_FRONT   1
`define GFX_V_SYNC    2
`define GFX_V_BACK    1
`define GFX_V_WHOLE   (`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

// RGB 4:4:4
`define GFX_PIXEL_BITS 12

// coordinate widths
`define GFX_X_BITS 4
`define GFX_Y_BITS 3

// one stripe bank holds half the frame
`define GFX_BANK_DEPTH     64
`define GFX_BANK_ADDR_BITS 6

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f gfx_vga_stripe.f \
  --top-module tb_gfx_vga_stripe \
  -o tb_gfx_vga_stripe_sim \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/tb_gfx_vga_stripe_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q 'All tests passed!' \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_gfx_vga_stripe.sv ====
`default_nettype none

`include "gfx_defs.svh"

module tb_gfx_vga_stripe
  import gfx_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 20;
  localparam int FRAME_CYCLES = `GFX_H_WHOLE * `GFX_V_WHOLE;
  localparam int FRAME_PIXELS = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
  localparam int CLEAR_CYCLES = `GFX_BANK_DEPTH;
  localparam int NUM_WRITES   = 32;
  localparam int NUM_STALLS   = 8;
  localparam int STALL_MAX    = 16;
  // six frames plus the clear, the writes and the longest stalls
  localparam int RUN_CYCLES   = 6 * FRAME_CYCLES + CLEAR_CYCLES + 1 + NUM_WRITES
                                + NUM_STALLS * STALL_MAX;

  typedef logic [`GFX_X_BITS-1:0] x_t;
  typedef logic [`GFX_Y_BITS-1:0] y_t;

  logic   clk;
  logic   rst;
  x_t     gfx_x;
  y_t     gfx_y;
  pixel_t gfx_color;
  logic   gfx_valid;
  logic   gfx_clear;
  logic   gfx_ready;
  logic   gfx_vsync;
  logic   vga_enable;
  pixel_t vga_color;
  logic   vga_hsync;
  logic   vga_vsync;
  logic   vga_visible;

  // what the screen should show, indexed [x][y]
  pixel_t model [`GFX_H_VISIBLE][`GFX_V_VISIBLE];

  int   err_count   = 0;
  int   pix_checked = 0;
  logic check_on    = 1'b0;
  int   seed;

  // output-side scan tracking
  int   scan_x         = 0;
  int   scan_y         = 0;
  int   vis_run        = 0;
  int   hs_low         = 0;
  int   vs_low         = 0;
  int   line_len       = 0;
  logic line_seen      = 1'b0;
  int   lines_in_frame = 0;
  logic prev_vis       = 1'b0;
  logic prev_hs        = 1'b1;
  logic prev_vs        = 1'b1;
  // gfx_vsync one and two display steps back
  logic gv_d1          = 1'b1;
  logic gv_d2          = 1'b1;

  gfx_vga_stripe gfx_vga_stripe_i (
    .clk        (clk),
    .rst        (rst),
    .gfx_x      (gfx_x),
    .gfx_y      (gfx_y),
    .gfx_color  (gfx_color),
    .gfx_valid  (gfx_valid),
    .gfx_clear  (gfx_clear),
    .gfx_ready  (gfx_ready),
    .gfx_vsync  (gfx_vsync),
    .vga_enable (vga_enable),
    .vga_color  (vga_color),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_visible(vga_visible)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  task report_value(input string name, input int got, input int want);
    $display("CHECK FAILED at %0t ns: %s = %0d (0x%0h), expected %0d (0x%0h)",
             $time, name, got, got, want, want);
    err_count++;
  endtask

  // reference for one screen position
  function automatic pixel_t expected_pixel(input x_t x, input y_t y);
    return model[x][y];
  endfunction

  // returns at the falling edge where gfx_vsync has just dropped
  task wait_vblank();
    logic last;
    logic now;
    last = 1'b0;
    now  = gfx_vsync;
    while (!(last && !now)) begin
      @(negedge clk);
      last = now;
      now  = gfx_vsync;
    end
  endtask

  task check_reset_state();
    if (gfx_ready !== 1'b1) report_value("gfx_ready", int'(gfx_ready), 1);
    if (gfx_vsync !== 1'b1) report_value("gfx_vsync", int'(gfx_vsync), 1);
    if (vga_hsync !== 1'b1) report_value("vga_hsync", int'(vga_hsync), 1);
    if (vga_vsync !== 1'b1) report_value("vga_vsync", int'(vga_vsync), 1);
    if (vga_visible !== 1'b0) report_value("vga_visible", int'(vga_visible), 0);
    if (vga_color !== '0) report_value("vga_color", int'(vga_color), 0);
  endtask

  task run_clear(input pixel_t fill);
    int low_cycles;
    gfx_color = fill;
    gfx_clear = 1'b1;
    for (int x = 0; x < `GFX_H_VISIBLE; x++) begin
      for (int y = 0; y < `GFX_V_VISIBLE; y++) begin
        model[x_t'(x)][y_t'(y)] = fill;
      end
    end
    @(negedge clk);
    low_cycles = 0;
    // one low cycle per swept word
    while (!gfx_ready && low_cycles < 4 * CLEAR_CYCLES) begin
      low_cycles++;
      gfx_clear = 1'b0;
      @(negedge clk);
    end
    gfx_clear = 1'b0;
    if (low_cycles != CLEAR_CYCLES) begin
      report_value("gfx_ready low cycles", low_cycles, CLEAR_CYCLES);
    end
  endtask

  task write_pixels(input int count);
    x_t     xr;
    y_t     yr;
    pixel_t cr;
    for (int i = 0; i < count; i++) begin
      xr = x_t'($urandom);
      // alternate even and odd stripes
      xr[0] = i[0];
      yr = y_t'($urandom);
      cr = pixel_t'($urandom);
      if (!gfx_ready) begin
        $display("ERROR at %0t ns: gfx_ready is low for a pixel write in idle", $time);
        err_count++;
      end
      gfx_x     = xr;
      gfx_y     = yr;
      gfx_color = cr;
      gfx_valid = 1'b1;
      model[xr][yr] = cr;
      @(negedge clk);
    end
    gfx_valid = 1'b0;
  endtask

  task stall_display();
    int gap;
    int hold;
    // first stall lands inside the visible lines
    gap = $urandom_range(110, 80);
    repeat (gap) @(negedge clk);
    for (int i = 0; i < NUM_STALLS; i++) begin
      hold = $urandom_range(STALL_MAX, 1);
      vga_enable = 1'b0;
      repeat (hold) @(negedge clk);
      vga_enable = 1'b1;
      gap = $urandom_range(23, 8);
      repeat (gap) @(negedge clk);
    end
  endtask

  // one display step, the outputs after an enabled edge
  task score_output();
    pixel_t want;
    if (!vga_visible && vga_color !== '0) begin
      report_value("vga_color in blanking", int'(vga_color), 0);
    end
    if (vga_visible) begin
      if (scan_y >= `GFX_V_VISIBLE) begin
        $display("ERROR at %0t ns: visible pixel after the last visible line", $time);
        err_count++;
      end else if (check_on) begin
        want = expected_pixel(x_t'(scan_x), y_t'(scan_y));
        if (vga_color !== want) begin
          report_value($sformatf("vga_color at x=%0d y=%0d", scan_x, scan_y),
                       int'(vga_color), int'(want));
        end
        pix_checked++;
      end
      vis_run++;
      scan_x++;
      if (scan_x == `GFX_H_VISIBLE) begin
        scan_x = 0;
        scan_y++;
      end
    end
    if (!vga_visible && prev_vis) begin
      if (vis_run != `GFX_H_VISIBLE) report_value("visible run length", vis_run, `GFX_H_VISIBLE);
      vis_run = 0;
      lines_in_frame++;
    end

    // hsync pulse and line period
    if (!vga_hsync) hs_low++;
    if (vga_hsync && !prev_hs) begin
      if (hs_low != `GFX_H_SYNC) report_value("vga_hsync low length", hs_low, `GFX_H_SYNC);
      hs_low = 0;
    end
    line_len++;
    if (!vga_hsync && prev_hs) begin
      if (line_seen && line_len != `GFX_H_WHOLE) begin
        report_value("line period", line_len, `GFX_H_WHOLE);
      end
      line_seen = 1'b1;
      line_len  = 0;
    end

    // vsync pulse, lines per frame, position restart
    if (!vga_vsync) vs_low++;
    if (vga_vsync && !prev_vs) begin
      if (vs_low != `GFX_V_SYNC * `GFX_H_WHOLE) begin
        report_value("vga_vsync low length", vs_low, `GFX_V_SYNC * `GFX_H_WHOLE);
      end
      vs_low = 0;
    end
    if (!vga_vsync && prev_vs) begin
      if (lines_in_frame != `GFX_V_VISIBLE) begin
        report_value("visible lines per frame", lines_in_frame, `GFX_V_VISIBLE);
      end
      lines_in_frame = 0;
      scan_x = 0;
      scan_y = 0;
    end

    // vga_vsync trails gfx_vsync by two steps
    if (vga_vsync !== gv_d2) report_value("vga_vsync vs early gfx_vsync", int'(vga_vsync),
                                          int'(gv_d2));
    gv_d2 = gv_d1;
    gv_d1 = gfx_vsync;

    prev_vis = vga_visible;
    prev_hs  = vga_hsync;
    prev_vs  = vga_vsync;
  endtask

  initial begin
    logic adv;
    @(negedge rst);
    forever begin
      @(posedge clk);
      adv = vga_enable;
      @(negedge clk);
      if (adv) score_output();
    end
  end

  initial begin
    int     pix_start;
    int     delta;
    pixel_t fill;
    rst        = 1'b1;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_valid  = 1'b0;
    gfx_clear  = 1'b0;
    vga_enable = 1'b1;
    seed       = $urandom(32'hbb7d);

    @(negedge clk);
    check_reset_state();
    @(negedge clk);
    rst = 1'b0;

    // whole-frame clear with a random color
    wait_vblank();
    fill = pixel_t'($urandom);
    run_clear(fill);
    check_on  = 1'b1;
    pix_start = pix_checked;
    wait_vblank();
    if (pix_checked - pix_start != FRAME_PIXELS) begin
      report_value("pixels compared after clear", pix_checked - pix_start, FRAME_PIXELS);
    end

    // random writes to both stripes during vertical blank
    pix_start = pix_checked;
    write_pixels(NUM_WRITES);
    wait_vblank();
    if (pix_checked - pix_start != FRAME_PIXELS) begin
      report_value("pixels compared after writes", pix_checked - pix_start, FRAME_PIXELS);
    end

    // display stalls in mid frame
    pix_start = pix_checked;
    stall_display();
    wait_vblank();
    delta = pix_checked - pix_start;
    if (delta == 0 || delta % FRAME_PIXELS != 0) begin
      $display("ERROR at %0t ns: %0d pixels seen across the stalls, not whole frames",
               $time, delta);
      err_count++;
    end

    $display("pixels compared: %0d, errors: %0d", pix_checked, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
